// File: rtl/mem_ctrl_macros.svh
`ifndef MEM_CTRL_MACROS_SVH
`define MEM_CTRL_MACROS_SVH

// ====================
// bus and address geometry
// ====================

`define MC_AWID 32 // byte address, offset and physical
`define MC_DWID 64 // one octa per bus beat

// transaction id carried from request to response
`define MC_TIDW 4

// ====================
// queue sizing
// ====================

`define MC_REQ_DEPTH 4
`define MC_RESP_DEPTH 4

`endif

// File: rtl/mem_op_pkg.sv
`default_nettype none

`include "mem_ctrl_macros.svh"

package mem_op_pkg;

	// ====================
	// operation encodings
	// ====================

	typedef enum logic [1:0] {
		FN_LOAD  = 2'b00, // sign extended
		FN_LOADZ = 2'b01, // zero extended
		FN_STORE = 2'b10,
		FN_RSVD  = 2'b11  // dropped at decode
	} mem_func_e;

	// access size, log2 of the byte count
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2,
		SZ_OCTA  = 2'd3
	} mem_size_e;

	// queued request, field order matters for packing at the top
	typedef struct packed {
		mem_func_e               func;
		mem_size_e               size;
		logic [`MC_AWID-1:0]     adr; // offset within segment
		logic [`MC_DWID-1:0]     dat; // store data, right justified
		logic [`MC_TIDW-1:0]     tid;
	} mem_req_t;

	typedef struct packed {
		logic [`MC_TIDW-1:0]     tid;
		logic                    fault;
		logic [`MC_DWID-1:0]     word; // load data or fault view
	} mem_resp_t;

endpackage

`default_nettype wire

// File: rtl/mem_bus_pkg.sv
`default_nettype none

`include "mem_ctrl_macros.svh"

package mem_bus_pkg;

	typedef logic [7:0] lane_sel_t; // one bit per byte lane

	typedef enum logic [7:0] {
		FLT_NONE = 8'h00,
		FLT_SGB  = 8'h81  // segment bounds
	} fault_cause_e;

	// fault layout of a response word
	typedef struct packed {
		fault_cause_e                        cause;
		logic [`MC_DWID-`MC_AWID-9:0]        pad;
		logic [`MC_AWID-1:0]                 badr; // faulting offset
	} fault_view_t;

	// read as data when the fault flag is clear, else as fault view
	typedef union packed {
		logic [`MC_DWID-1:0] data;
		fault_view_t         flt;
	} resp_word_u;

endpackage

`default_nettype wire

// File: rtl/mem_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_macros.svh"

// decoded operation, decode to execute
interface mem_op_if import mem_op_pkg::*, mem_bus_pkg::*; ();
	logic                 valid;
	logic                 ready;
	mem_func_e            func;
	mem_size_e            size;
	logic [`MC_AWID-1:0]  padr; // segment base added
	lane_sel_t            sel;
	logic [`MC_DWID-1:0]  dat;  // already in its lanes
	logic [`MC_TIDW-1:0]  tid;
	logic                 fault;
	fault_cause_e         cause;
	logic [`MC_AWID-1:0]  oadr; // aligned offset

	modport source (output valid, func, size, padr, sel, dat, tid, fault, cause, oadr,
		input ready);
	modport sink (input valid, func, size, padr, sel, dat, tid, fault, cause, oadr,
		output ready);
endinterface

// completed bus operation, execute to result
interface mem_res_if import mem_op_pkg::*, mem_bus_pkg::*; ();
	logic                 valid;
	logic                 ready;
	mem_func_e            func;
	mem_size_e            size;
	logic [2:0]           boff; // byte lane of the access
	logic [`MC_DWID-1:0]  rdat; // raw bus word
	logic [`MC_TIDW-1:0]  tid;
	logic                 fault;
	fault_cause_e         cause;
	logic [`MC_AWID-1:0]  oadr;

	modport source (output valid, func, size, boff, rdat, tid, fault, cause, oadr,
		input ready);
	modport sink (input valid, func, size, boff, rdat, tid, fault, cause, oadr,
		output ready);
endinterface

`default_nettype wire

// File: rtl/mem_queue.sv
`timescale 1ns/1ps
`default_nettype none

module mem_queue #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  wire              clk,
	input  wire              rst,
	input  wire              wr_i,
	input  wire [WIDTH-1:0]  wdata_i,
	input  wire              rd_i,
	output logic [WIDTH-1:0] rdata_o,
	output logic             full_o,
	output logic             empty_o
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PW-1:0]    wr_ptr;
	logic [PW-1:0]    rd_ptr;
	logic [PW:0]      count;
	logic             do_wr;
	logic             do_rd;

	assign full_o  = count == (PW+1)'(DEPTH);
	assign empty_o = count == '0;
	assign do_wr   = wr_i && !full_o;  // dropped when full
	assign do_rd   = rd_i && !empty_o;
	assign rdata_o = mem[rd_ptr];      // head shown ahead of the read

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wdata_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/mem_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_macros.svh"

module mem_decode import mem_op_pkg::*, mem_bus_pkg::*; (
	input  wire                 clk,
	input  wire                 rst,
	input  wire mem_req_t       req_i,
	input  wire                 req_empty_i,
	output logic                req_pop_o,
	input  wire [`MC_AWID-1:0]  seg_base_i,
	input  wire [`MC_AWID-1:0]  seg_limit_i,
	input  wire                 bounds_chk_i,
	mem_op_if.source            op
);

	logic [`MC_AWID-1:0] aoff;
	logic [`MC_AWID-1:0] padr;
	lane_sel_t           size_mask;
	logic                seg_flt;

	// ====================
	// address formation
	// ====================

	always_comb begin
		// bits below the access size are ignored
		aoff    = req_i.adr & ({`MC_AWID{1'b1}} << req_i.size);
		padr    = seg_base_i + aoff; // base is expected octa aligned
		seg_flt = bounds_chk_i && (aoff > seg_limit_i);
		case (req_i.size)
			SZ_BYTE:  size_mask = 8'h01;
			SZ_WYDE:  size_mask = 8'h03;
			SZ_TETRA: size_mask = 8'h0f;
			default:  size_mask = 8'hff;
		endcase
	end

	// take the head when the output stage is free or draining
	assign req_pop_o = !req_empty_i && (!op.valid || op.ready);

	always_ff @(posedge clk) begin
		if (rst) begin
			op.valid <= 1'b0;
		end else if (req_pop_o) begin
			op.valid <= req_i.func != FN_RSVD; // unknown function discarded
		end else if (op.ready) begin
			op.valid <= 1'b0;
		end
	end

	// ====================
	// lane placement
	// ====================

	always_ff @(posedge clk) begin
		if (req_pop_o) begin
			op.func  <= req_i.func;
			op.size  <= req_i.size;
			op.padr  <= padr;
			op.sel   <= size_mask << padr[2:0];
			op.dat   <= req_i.dat << {padr[2:0], 3'b000}; // into its byte lanes
			op.tid   <= req_i.tid;
			op.fault <= seg_flt;
			op.cause <= seg_flt ? FLT_SGB : FLT_NONE;
			op.oadr  <= aoff;
		end
	end

endmodule

`default_nettype wire

// File: rtl/mem_bus_cycle.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_macros.svh"

module mem_bus_cycle import mem_op_pkg::*, mem_bus_pkg::*; (
	input  wire                 clk,
	input  wire                 rst,
	mem_op_if.sink              op,
	mem_res_if.source           res,
	output logic                cyc_o,
	output logic                stb_o,
	output logic                we_o,
	output lane_sel_t           sel_o,
	output logic [`MC_AWID-1:0] adr_o,
	output logic [`MC_DWID-1:0] dat_o,
	input  wire [`MC_DWID-1:0]  dat_i,
	input  wire                 ack_i
);

	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_ACTIVE = 2'd1; // waiting on ack
	localparam logic [1:0] ST_DONE   = 2'd2; // result offered

	logic [1:0] state;
	logic       op_take;
	logic       bus_end;

	assign op.ready  = state == ST_IDLE;
	assign res.valid = state == ST_DONE;
	assign op_take   = op.valid && op.ready;
	assign bus_end   = (state == ST_ACTIVE) && ack_i;

	// ====================
	// cycle control
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			cyc_o <= 1'b0;
			stb_o <= 1'b0;
			we_o  <= 1'b0;
			sel_o <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (op_take && op.fault) begin
						state <= ST_DONE; // no bus cycle for a fault
					end else if (op_take) begin
						state <= ST_ACTIVE;
						cyc_o <= 1'b1;
						stb_o <= 1'b1;
						we_o  <= op.func == FN_STORE;
						sel_o <= op.sel;
					end
				end
				ST_ACTIVE: begin
					if (ack_i) begin
						state <= ST_DONE;
						cyc_o <= 1'b0;
						stb_o <= 1'b0;
						we_o  <= 1'b0;
						sel_o <= '0;
					end
				end
				ST_DONE: begin
					if (res.ready)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// address, write data and the operation travel with the cycle
	always_ff @(posedge clk) begin
		if (op_take) begin
			adr_o     <= op.padr;
			dat_o     <= op.dat;
			res.func  <= op.func;
			res.size  <= op.size;
			res.boff  <= op.padr[2:0];
			res.tid   <= op.tid;
			res.fault <= op.fault;
			res.cause <= op.cause;
			res.oadr  <= op.oadr;
			res.rdat  <= '0;
		end else if (bus_end) begin
			res.rdat <= dat_i; // captured on the ack edge
		end
	end

endmodule

`default_nettype wire

// File: rtl/mem_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_macros.svh"

module mem_result import mem_op_pkg::*, mem_bus_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	mem_res_if.sink    res,
	output mem_resp_t  resp_o,
	output logic       resp_wr_o,
	input  wire        resp_full_i
);

	logic [`MC_DWID-1:0] shifted;
	logic [`MC_DWID-1:0] load_val;
	logic                sext;
	resp_word_u          word;
	logic                take;

	// one write in flight at a time, so full is never stale
	assign res.ready = !resp_full_i && !resp_wr_o;
	assign take      = res.valid && res.ready;

	// ====================
	// load extraction
	// ====================

	always_comb begin
		shifted = res.rdat >> {res.boff, 3'b000};
		sext    = res.func == FN_LOAD;
		case (res.size)
			SZ_BYTE:  load_val = {{(`MC_DWID-8){sext & shifted[7]}}, shifted[7:0]};
			SZ_WYDE:  load_val = {{(`MC_DWID-16){sext & shifted[15]}}, shifted[15:0]};
			SZ_TETRA: load_val = {{(`MC_DWID-32){sext & shifted[31]}}, shifted[31:0]};
			default:  load_val = shifted;
		endcase

		word.data = '0; // stores answer with zero
		if (res.fault) begin
			word.flt.cause = res.cause;
			word.flt.pad   = '0;
			word.flt.badr  = res.oadr;
		end else if (res.func == FN_LOAD || res.func == FN_LOADZ) begin
			word.data = load_val;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			resp_wr_o <= 1'b0;
		else
			resp_wr_o <= take;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			resp_o.tid   <= res.tid;
			resp_o.fault <= res.fault;
			resp_o.word  <= word;
		end
	end

endmodule

`default_nettype wire

// File: rtl/mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_macros.svh"

module mem_ctrl import mem_op_pkg::*; (
	input  wire                 clk,
	input  wire                 rst,
	// request side
	input  wire                 req_wr_i,
	input  wire [1:0]           req_func_i,
	input  wire [1:0]           req_size_i,
	input  wire [`MC_AWID-1:0]  req_adr_i,
	input  wire [`MC_DWID-1:0]  req_dat_i,
	input  wire [`MC_TIDW-1:0]  req_tid_i,
	output logic                req_full_o,
	// response side
	input  wire                 resp_rd_i,
	output logic                resp_empty_o,
	output logic [`MC_TIDW-1:0] resp_tid_o,
	output logic                resp_fault_o,
	output logic [`MC_DWID-1:0] resp_word_o,
	// segment
	input  wire [`MC_AWID-1:0]  seg_base_i,
	input  wire [`MC_AWID-1:0]  seg_limit_i,
	input  wire                 bounds_chk_i,
	// bus master
	output logic                cyc_o,
	output logic                stb_o,
	output logic                we_o,
	output logic [7:0]          sel_o,
	output logic [`MC_AWID-1:0] adr_o,
	output logic [`MC_DWID-1:0] dat_o,
	input  wire [`MC_DWID-1:0]  dat_i,
	input  wire                 ack_i
);

	mem_req_t  req_wdata;
	mem_req_t  req_head;
	logic      req_empty;
	logic      req_pop;
	mem_resp_t resp_wdata;
	mem_resp_t resp_head;
	logic      resp_wr;
	logic      resp_full;

	mem_op_if  u_op_if ();
	mem_res_if u_res_if ();

	// same order as the struct fields
	assign req_wdata = {req_func_i, req_size_i, req_adr_i, req_dat_i, req_tid_i};

	assign resp_tid_o   = resp_head.tid;
	assign resp_fault_o = resp_head.fault;
	assign resp_word_o  = resp_head.word;

	// ====================
	// queues and stages
	// ====================

	mem_queue #(.WIDTH($bits(mem_req_t)), .DEPTH(`MC_REQ_DEPTH)) u_req_q (
		.clk(clk), .rst(rst),
		.wr_i(req_wr_i), .wdata_i(req_wdata),
		.rd_i(req_pop), .rdata_o(req_head),
		.full_o(req_full_o), .empty_o(req_empty)
	);

	mem_decode u_decode (
		.clk(clk), .rst(rst),
		.req_i(req_head), .req_empty_i(req_empty), .req_pop_o(req_pop),
		.seg_base_i(seg_base_i), .seg_limit_i(seg_limit_i), .bounds_chk_i(bounds_chk_i),
		.op(u_op_if.source)
	);

	mem_bus_cycle u_bus_cycle (
		.clk(clk), .rst(rst),
		.op(u_op_if.sink), .res(u_res_if.source),
		.cyc_o(cyc_o), .stb_o(stb_o), .we_o(we_o), .sel_o(sel_o),
		.adr_o(adr_o), .dat_o(dat_o), .dat_i(dat_i), .ack_i(ack_i)
	);

	mem_result u_result (
		.clk(clk), .rst(rst),
		.res(u_res_if.sink),
		.resp_o(resp_wdata), .resp_wr_o(resp_wr), .resp_full_i(resp_full)
	);

	mem_queue #(.WIDTH($bits(mem_resp_t)), .DEPTH(`MC_RESP_DEPTH)) u_resp_q (
		.clk(clk), .rst(rst),
		.wr_i(resp_wr), .wdata_i(resp_wdata),
		.rd_i(resp_rd_i), .rdata_o(resp_head),
		.full_o(resp_full), .empty_o(resp_empty_o)
	);

endmodule

`default_nettype wire

// File: test/mem_ctrl_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_macros.svh"

module mem_ctrl_assertions (
	input wire                clk,
	input wire                rst,
	input wire                cyc_o,
	input wire                stb_o,
	input wire                we_o,
	input wire [7:0]          sel_o,
	input wire [`MC_AWID-1:0] adr_o,
	input wire [`MC_DWID-1:0] dat_o,
	input wire                ack_i
);

	int fail_cnt = 0; // failed protocol checks so far

	// ====================
	// bus protocol
	// ====================

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) stb_o |-> cyc_o)
		else begin
			$error("stb_o high without cyc_o");
			fail_cnt++;
		end

	a_sel_nonzero: assert property (@(posedge clk) disable iff (rst) stb_o |-> sel_o != 8'h00)
		else begin
			$error("sel_o is zero during a strobe");
			fail_cnt++;
		end

	// master holds everything until the slave acks
	a_hold: assert property (@(posedge clk) disable iff (rst)
		stb_o && !ack_i |=> $stable(adr_o) && $stable(sel_o) && $stable(we_o) && $stable(dat_o))
		else begin
			$error("bus outputs changed before ack_i");
			fail_cnt++;
		end

	a_reset_idle: assert property (@(posedge clk) rst |=> !cyc_o)
		else begin
			$error("cyc_o high in the cycle after reset");
			fail_cnt++;
		end

endmodule

bind mem_ctrl mem_ctrl_assertions u_assert (
	.clk(clk), .rst(rst), .cyc_o(cyc_o), .stb_o(stb_o), .we_o(we_o),
	.sel_o(sel_o), .adr_o(adr_o), .dat_o(dat_o), .ack_i(ack_i)
);

`default_nettype wire

// File: test/mem_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_macros.svh"

module mem_ctrl_tb import mem_op_pkg::*; ();

	localparam int N_T2 = 24;
	localparam int N_T3 = 24;
	localparam int N_T4 = 16;
	localparam int N_T5 = 12;
	localparam int N_T6 = 12;
	localparam int TOTAL_OPS = N_T2 + N_T3 + N_T4 + N_T5 + N_T6;
	localparam int CYCLE_LIMIT = 20 * TOTAL_OPS + 200;

	logic clk, rst;
	logic req_wr_i, resp_rd_i, bounds_chk_i, ack_i;
	logic [1:0] req_func_i, req_size_i;
	logic [`MC_AWID-1:0] req_adr_i, seg_base_i, seg_limit_i;
	logic [`MC_DWID-1:0] req_dat_i, dat_i;
	logic [`MC_TIDW-1:0] req_tid_i;
	wire req_full_o, resp_empty_o, resp_fault_o, cyc_o, stb_o, we_o;
	wire [`MC_TIDW-1:0] resp_tid_o;
	wire [`MC_DWID-1:0] resp_word_o, dat_o;
	wire [7:0] sel_o;
	wire [`MC_AWID-1:0] adr_o;

	logic [63:0] slave_mem [logic [31:0]];
	logic [63:0] model_mem [logic [31:0]];
	logic [3:0]  exp_tid [$];
	logic        exp_flt [$];
	logic [63:0] exp_word [$];
	logic [3:0]  tid_ctr, e_tid;
	logic        e_flt, drain_en, saw_full;
	logic [63:0] e_word, s_word;
	logic [31:0] s_widx;
	logic [1:0]  sz_l [16];
	logic [1:0]  fn_l [16];
	logic [31:0] adr_l [16];
	int          checks, errors, err_mark, bus_cycles, bc0, cycles, s_wait, total;

	mem_ctrl u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// background pattern over the whole word address
	function automatic logic [63:0] fill_word(input logic [31:0] widx);
		return {widx ^ 32'ha5c3_0f17, ~widx};
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s: %s", name, (errors == err_mark) ? "passed" : "failed");
		err_mark = errors;
	endtask

	// ====================
	// reference model
	// ====================

	task automatic issue(input logic [1:0] func, input logic [1:0] size,
		input logic [31:0] adr, input logic [63:0] dat);
		logic [31:0] aoff;
		logic [31:0] padr;
		logic [31:0] widx;
		logic [63:0] word;
		logic [63:0] res;
		logic        sign;
		int          nbytes;
		int          off;
		aoff   = adr & ~((32'd1 << size) - 32'd1); // natural alignment
		nbytes = 1 << size;
		padr   = seg_base_i + aoff;
		off    = int'(padr[2:0]);
		widx   = padr >> 3;
		word   = model_mem.exists(widx) ? model_mem[widx] : fill_word(widx);
		res    = '0;
		if (func == FN_RSVD) begin
			// discarded, no response expected
		end else if (bounds_chk_i && aoff > seg_limit_i) begin
			exp_tid.push_back(tid_ctr);
			exp_flt.push_back(1'b1);
			exp_word.push_back({8'h81, 24'h0, aoff});
		end else begin
			if (func == FN_STORE) begin
				for (int i = 0; i < nbytes; i++)
					word[(off+i)*8 +: 8] = dat[i*8 +: 8];
				model_mem[widx] = word;
			end else begin
				for (int i = 0; i < nbytes; i++)
					res[i*8 +: 8] = word[(off+i)*8 +: 8];
				sign = (func == FN_LOAD) && res[nbytes*8-1];
				for (int i = nbytes; i < 8; i++)
					res[i*8 +: 8] = {8{sign}};
			end
			exp_tid.push_back(tid_ctr);
			exp_flt.push_back(1'b0);
			exp_word.push_back(res); // zero for stores
		end
		while (req_full_o)
			step();
		req_func_i = func;
		req_size_i = size;
		req_adr_i  = adr;
		req_dat_i  = dat;
		req_tid_i  = tid_ctr;
		req_wr_i   = 1'b1;
		step();
		req_wr_i = 1'b0;
		tid_ctr++;
	endtask

	task automatic wait_drain();
		while (exp_tid.size() != 0)
			step();
	endtask

	// ====================
	// bus slave
	// ====================

	initial begin
		ack_i = 1'b0;
		dat_i = '0;
		bus_cycles = 0;
		forever begin
			step();
			if (stb_o && !rst) begin
				s_wait = int'($urandom % 4);
				repeat (s_wait)
					step();
				s_widx = adr_o >> 3;
				s_word = slave_mem.exists(s_widx) ? slave_mem[s_widx] : fill_word(s_widx);
				if (we_o) begin
					for (int i = 0; i < 8; i++)
						if (sel_o[i])
							s_word[i*8 +: 8] = dat_o[i*8 +: 8];
					slave_mem[s_widx] = s_word;
				end
				dat_i = s_word;
				ack_i = 1'b1;
				bus_cycles++;
				step();
				ack_i = 1'b0;
			end
		end
	end

	// response checker, pops one per cycle while draining
	initial begin
		resp_rd_i = 1'b0;
		forever begin
			step();
			resp_rd_i = 1'b0;
			if (drain_en && !rst && !resp_empty_o) begin
				if (exp_tid.size() == 0) begin
					assert (0) else begin
						$display("response with id %0h arrived but none was expected", resp_tid_o);
						errors++;
					end
				end else begin
					e_tid  = exp_tid.pop_front();
					e_flt  = exp_flt.pop_front();
					e_word = exp_word.pop_front();
					check_val("resp_tid_o", resp_tid_o, e_tid);
					check_val("resp_fault_o", resp_fault_o, e_flt);
					check_val("resp_word_o", resp_word_o, e_word);
				end
				resp_rd_i = 1'b1;
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("ERRORS FOUND");
		$finish;
	end

	// ====================
	// test sequence
	// ====================

	initial begin
		void'($urandom(32'h6045_d2ae));
		rst = 1'b1;
		req_wr_i = 1'b0;
		req_func_i = '0;
		req_size_i = '0;
		req_adr_i = '0;
		req_dat_i = '0;
		req_tid_i = '0;
		seg_base_i = 32'h0000_1000;
		seg_limit_i = 32'h0000_03ff;
		bounds_chk_i = 1'b1;
		drain_en = 1'b1;
		tid_ctr = '0;
		checks = 0;
		errors = 0;
		err_mark = 0;
		repeat (8)
			step();
		rst = 1'b0;
		repeat (2)
			step();

		check_val("cyc_o", cyc_o, 0);
		check_val("stb_o", stb_o, 0);
		check_val("we_o", we_o, 0);
		check_val("resp_empty_o", resp_empty_o, 1);
		check_val("req_full_o", req_full_o, 0);
		report_test("reset state");

		for (int i = 0; i < N_T2 / 2; i++) begin
			sz_l[i]  = 2'($urandom % 4);
			adr_l[i] = $urandom % 32'h80;
			issue(FN_STORE, sz_l[i], adr_l[i], {$urandom, $urandom});
		end
		for (int i = 0; i < N_T2 / 2; i++)
			issue(FN_LOAD, sz_l[i], adr_l[i], 64'h0);
		wait_drain();
		report_test("store then sign extended load");

		// small region so lanes of partial stores overlap
		for (int i = 0; i < N_T3 / 2; i++)
			issue(FN_STORE, 2'($urandom % 4), 32'h200 + $urandom % 32'h20, {$urandom, $urandom});
		for (int i = 0; i < N_T3 / 2; i++)
			issue(FN_LOADZ, 2'($urandom % 4), 32'h200 + $urandom % 32'h20, 64'h0);
		wait_drain();
		report_test("zero extended load");

		bc0 = bus_cycles;
		for (int i = 0; i < N_T4 / 2; i++) begin
			fn_l[i]  = 2'($urandom % 3);
			sz_l[i]  = 2'($urandom % 4);
			adr_l[i] = 32'h400 + $urandom % 32'hc00; // above the limit
			issue(fn_l[i], sz_l[i], adr_l[i], {$urandom, $urandom});
		end
		wait_drain();
		check_val("bus cycle count", 64'(bus_cycles), 64'(bc0));
		bounds_chk_i = 1'b0;
		for (int i = 0; i < N_T4 / 2; i++)
			issue(fn_l[i], sz_l[i], adr_l[i], {$urandom, $urandom});
		wait_drain();
		bounds_chk_i = 1'b1;
		report_test("segment bounds");

		drain_en = 1'b0;
		saw_full = 1'b0;
		for (int i = 0; i < N_T5; i++) begin
			while (req_full_o) begin
				saw_full = 1'b1;
				drain_en = 1'b1;
				step();
			end
			issue(2'($urandom % 3), 2'($urandom % 4), $urandom % 32'h100, {$urandom, $urandom});
		end
		drain_en = 1'b1;
		wait_drain();
		assert (saw_full) else begin
			$display("req_full_o never rose while responses were held back");
			errors++;
		end
		report_test("back-pressure");

		for (int i = 0; i < N_T6; i++)
			issue(2'($urandom % 4), 2'($urandom % 4), $urandom % 32'h100, {$urandom, $urandom});
		wait_drain();
		drain_en = 1'b0; // leave any stray response in the queue
		repeat (20)
			step();
		check_val("resp_empty_o", resp_empty_o, 1);
		report_test("reserved function");

		total = errors + u_dut.u_assert.fail_cnt;
		$display("checks %0d, errors %0d", checks, total);
		if (total == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: mem_ctrl.f
+incdir+rtl
rtl/mem_op_pkg.sv
rtl/mem_bus_pkg.sv
rtl/mem_stage_if.sv
rtl/mem_queue.sv
rtl/mem_decode.sv
rtl/mem_bus_cycle.sv
rtl/mem_result.sv
rtl/mem_ctrl.sv
test/mem_ctrl_assertions.sv
test/mem_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the mem_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module mem_ctrl_tb -f mem_ctrl.f -o Vmem_ctrl_tb
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/Vmem_ctrl_tb +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "NO ERRORS" <<< "$sim_out"; then
	exit 0
fi
echo "simulation reported failures"
exit 1
